// File: verilog/mipsCfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and address width
`define XLEN 32

// register index width for 32 registers
`define REG_ADDR_BITS 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// bytes per instruction word
`define INSTR_BYTES 4

`endif

// File: verilog/mipsPkg.sv
`include "mipsCfg.svh"

package mipsPkg;

	typedef logic [`XLEN-1:0] wordT;
	typedef logic [`REG_ADDR_BITS-1:0] regAddrT;

	// primary opcode in bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opLui   = 6'h0f
	} opcodeE;

	// r-type function field in bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluPassB
	} aluOpE;

	typedef enum logic [1:0] {
		srcReg,
		srcSignImm,
		srcZeroImm,
		srcUpperImm
	} srcBSelE;

endpackage

// File: verilog/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input  logic CLK,
	input  logic rst,
	input  mipsPkg::regAddrT rsD,
	input  mipsPkg::regAddrT rtD,
	input  mipsPkg::regAddrT rsE,
	input  mipsPkg::regAddrT rtE,
	input  mipsPkg::regAddrT destE,
	input  mipsPkg::regAddrT destW,
	input  logic isBranchD,
	input  logic branchTaken,
	input  logic regWriteE,
	input  logic regWriteW,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic forwardA,
	output logic forwardB
);

	logic branchDepE;

	// branch compare in decode cannot see a result still in execute
	assign branchDepE = isBranchD && regWriteE && ((rsD == destE) || (rtD == destE));

	// hold fetch and decode and send a bubble down
	assign stallF = branchDepE;
	assign stallD = branchDepE;
	assign flushE = branchDepE;

	// drop the wrong-path instruction behind a taken branch
	assign flushD = branchTaken;

	// writeback result overrides a stale register read
	assign forwardA = regWriteW && (rsE == destW);
	assign forwardB = regWriteW && (rtE == destW);

	// decode suppresses the compare during a stall
	assertNoFlushOnStall: assert property (@(posedge CLK) disable iff (rst)
		!(flushD && stallD));

	// the bubble clears the dependency so a stall never repeats
	assertStallOneCycle: assert property (@(posedge CLK) disable iff (rst)
		stallD |=> !stallD);

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/100ps
`include "mipsCfg.svh"

module fetchStage (
	input  logic CLK,
	input  logic rst,
	input  mipsPkg::wordT instr,
	input  logic branchTaken,
	input  mipsPkg::wordT branchTarget,
	input  logic stallF,
	input  logic stallD,
	input  logic flushD,
	output mipsPkg::wordT fetchPc,
	output mipsPkg::wordT instrD,
	output mipsPkg::wordT pcPlus4D
);

	mipsPkg::wordT pcPlus4F;

	assign pcPlus4F = fetchPc + `XLEN'(`INSTR_BYTES);

	// program counter
	always_ff @(posedge CLK) begin
		if (rst) begin
			fetchPc <= `RESET_PC;
		end else if (!stallF) begin
			fetchPc <= branchTaken ? branchTarget : pcPlus4F;
		end
	end

	// all-zero word decodes as a bubble
	always_ff @(posedge CLK) begin
		if (rst || flushD) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instr;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stallD) begin
			pcPlus4D <= pcPlus4F;
		end
	end

	assertPcAligned: assert property (@(posedge CLK) disable iff (rst)
		fetchPc[1:0] == 2'b00);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/100ps
`include "mipsCfg.svh"

module regFile (
	input  logic CLK,
	input  logic rst,
	input  mipsPkg::regAddrT rs,
	input  mipsPkg::regAddrT rt,
	input  logic regWrite,
	input  mipsPkg::regAddrT dest,
	input  mipsPkg::wordT writeData,
	output mipsPkg::wordT rsVal,
	output mipsPkg::wordT rtVal
);

	mipsPkg::wordT regs [1 << `REG_ADDR_BITS];

	// register 0 reads zero and a same-cycle write wins
	function automatic mipsPkg::wordT readPort(input mipsPkg::regAddrT idx);
		if (idx == '0) begin
			return '0;
		end else if (regWrite && (dest == idx)) begin
			return writeData;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < (1 << `REG_ADDR_BITS); i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[dest] <= writeData;
		end
	end

	always_comb begin
		rsVal = readPort(rs);
		rtVal = readPort(rt);
	end

	// decoder already drops writes to register 0
	assertNoWriteZero: assert property (@(posedge CLK) disable iff (rst)
		regWrite |-> (dest != '0));

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/100ps
`include "mipsCfg.svh"

module decodeStage (
	input  logic CLK,
	input  logic rst,
	input  mipsPkg::wordT instrD,
	input  mipsPkg::wordT pcPlus4D,
	input  mipsPkg::wordT rsVal,
	input  mipsPkg::wordT rtVal,
	input  logic stallD,
	input  logic flushE,
	output mipsPkg::regAddrT rsD,
	output mipsPkg::regAddrT rtD,
	output logic isBranchD,
	output logic branchTaken,
	output mipsPkg::wordT branchTarget,
	output logic regWriteE,
	output mipsPkg::aluOpE aluOpE,
	output mipsPkg::srcBSelE srcBSelE,
	output mipsPkg::wordT rsValE,
	output mipsPkg::wordT rtValE,
	output mipsPkg::regAddrT rsE,
	output mipsPkg::regAddrT rtE,
	output mipsPkg::regAddrT destE,
	output mipsPkg::wordT immSignE,
	output mipsPkg::wordT immZeroE,
	output mipsPkg::wordT immUpperE
);

	mipsPkg::opcodeE op;
	mipsPkg::functE funct;
	mipsPkg::regAddrT rdD;
	mipsPkg::regAddrT destD;
	mipsPkg::aluOpE aluOpD;
	mipsPkg::srcBSelE srcBSelD;
	mipsPkg::wordT immSignD;
	mipsPkg::wordT immZeroD;
	mipsPkg::wordT immUpperD;
	logic writesD;
	logic regWriteD;
	logic operandsEq;

	assign op = mipsPkg::opcodeE'(instrD[31:26]);
	assign funct = mipsPkg::functE'(instrD[5:0]);
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];

	// immediate forms
	assign immSignD = {{(`XLEN-16){instrD[15]}}, instrD[15:0]};
	assign immZeroD = {{(`XLEN-16){1'b0}}, instrD[15:0]};
	assign immUpperD = {instrD[15:0], {(`XLEN-16){1'b0}}};

	always_comb begin
		writesD = 1'b0;
		isBranchD = 1'b0;
		destD = rtD;
		aluOpD = mipsPkg::aluAdd;
		srcBSelD = mipsPkg::srcReg;
		case (op)
			mipsPkg::opRType: begin
				destD = rdD;
				writesD = 1'b1;
				case (funct)
					mipsPkg::fnAdd: aluOpD = mipsPkg::aluAdd;
					mipsPkg::fnSub: aluOpD = mipsPkg::aluSub;
					mipsPkg::fnAnd: aluOpD = mipsPkg::aluAnd;
					mipsPkg::fnOr: aluOpD = mipsPkg::aluOr;
					mipsPkg::fnSlt: aluOpD = mipsPkg::aluSlt;
					default: writesD = 1'b0;
				endcase
			end
			mipsPkg::opBeq,
			mipsPkg::opBne: isBranchD = 1'b1;
			mipsPkg::opAddi: begin
				writesD = 1'b1;
				srcBSelD = mipsPkg::srcSignImm;
			end
			mipsPkg::opAndi: begin
				writesD = 1'b1;
				aluOpD = mipsPkg::aluAnd;
				srcBSelD = mipsPkg::srcZeroImm;
			end
			mipsPkg::opOri: begin
				writesD = 1'b1;
				aluOpD = mipsPkg::aluOr;
				srcBSelD = mipsPkg::srcZeroImm;
			end
			mipsPkg::opLui: begin
				writesD = 1'b1;
				aluOpD = mipsPkg::aluPassB;
				srcBSelD = mipsPkg::srcUpperImm;
			end
			default: writesD = 1'b0;
		endcase
	end

	// writes to register 0 become bubbles here
	assign regWriteD = writesD && (destD != '0);

	// resolved once, after any stall has cleared
	assign operandsEq = (rsVal == rtVal);
	assign branchTaken = !stallD && (((op == mipsPkg::opBeq) && operandsEq) ||
		((op == mipsPkg::opBne) && !operandsEq));
	assign branchTarget = pcPlus4D + {immSignD[`XLEN-3:0], 2'b00};

	always_ff @(posedge CLK) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
		end
	end

	always_ff @(posedge CLK) begin
		aluOpE <= aluOpD;
		srcBSelE <= srcBSelD;
		rsValE <= rsVal;
		rtValE <= rtVal;
		rsE <= rsD;
		rtE <= rtD;
		destE <= destD;
		immSignE <= immSignD;
		immZeroE <= immZeroD;
		immUpperE <= immUpperD;
	end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/100ps
`include "mipsCfg.svh"

module executeStage (
	input  logic CLK,
	input  logic rst,
	input  logic regWriteE,
	input  mipsPkg::aluOpE aluOpE,
	input  mipsPkg::srcBSelE srcBSelE,
	input  mipsPkg::wordT rsValE,
	input  mipsPkg::wordT rtValE,
	input  mipsPkg::regAddrT destE,
	input  mipsPkg::wordT immSignE,
	input  mipsPkg::wordT immZeroE,
	input  mipsPkg::wordT immUpperE,
	input  logic forwardA,
	input  logic forwardB,
	output logic regWriteW,
	output mipsPkg::regAddrT destW,
	output mipsPkg::wordT resultW
);

	mipsPkg::wordT srcA;
	mipsPkg::wordT regB;
	mipsPkg::wordT srcB;
	mipsPkg::wordT aluOut;
	logic lessThan;

	// forwarding from writeback
	assign srcA = forwardA ? resultW : rsValE;
	assign regB = forwardB ? resultW : rtValE;

	always_comb begin
		case (srcBSelE)
			mipsPkg::srcSignImm: srcB = immSignE;
			mipsPkg::srcZeroImm: srcB = immZeroE;
			mipsPkg::srcUpperImm: srcB = immUpperE;
			default: srcB = regB;
		endcase
	end

	// slt compares as signed
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (aluOpE)
			mipsPkg::aluAdd: aluOut = srcA + srcB;
			mipsPkg::aluSub: aluOut = srcA - srcB;
			mipsPkg::aluAnd: aluOut = srcA & srcB;
			mipsPkg::aluOr: aluOut = srcA | srcB;
			mipsPkg::aluSlt: aluOut = {{(`XLEN-1){1'b0}}, lessThan};
			mipsPkg::aluPassB: aluOut = srcB;
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			regWriteW <= 1'b0;
		end else begin
			regWriteW <= regWriteE;
		end
	end

	always_ff @(posedge CLK) begin
		destW <= destE;
		resultW <= aluOut;
	end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
	input  logic CLK,
	input  logic rst,
	input  mipsPkg::wordT instr,
	output mipsPkg::wordT fetchPc,
	output logic retireValid,
	output mipsPkg::regAddrT retireReg,
	output mipsPkg::wordT retireData
);

	// fetch and decode
	mipsPkg::wordT instrD;
	mipsPkg::wordT pcPlus4D;
	mipsPkg::wordT branchTarget;
	logic branchTaken;
	logic isBranchD;
	mipsPkg::regAddrT rsD;
	mipsPkg::regAddrT rtD;
	mipsPkg::wordT rsVal;
	mipsPkg::wordT rtVal;

	// execute fields
	logic regWriteE;
	mipsPkg::aluOpE aluOpE;
	mipsPkg::srcBSelE srcBSelE;
	mipsPkg::wordT rsValE;
	mipsPkg::wordT rtValE;
	mipsPkg::regAddrT rsE;
	mipsPkg::regAddrT rtE;
	mipsPkg::regAddrT destE;
	mipsPkg::wordT immSignE;
	mipsPkg::wordT immZeroE;
	mipsPkg::wordT immUpperE;

	// writeback
	logic regWriteW;
	mipsPkg::regAddrT destW;
	mipsPkg::wordT resultW;

	// hazard controls
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	logic forwardA;
	logic forwardB;

	fetchStage i_fetch (
		.CLK(CLK), .rst(rst), .instr(instr),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.stallF(stallF), .stallD(stallD), .flushD(flushD),
		.fetchPc(fetchPc), .instrD(instrD), .pcPlus4D(pcPlus4D)
	);

	regFile i_regFile (
		.CLK(CLK), .rst(rst), .rs(rsD), .rt(rtD),
		.regWrite(regWriteW), .dest(destW), .writeData(resultW),
		.rsVal(rsVal), .rtVal(rtVal)
	);

	decodeStage i_decode (
		.CLK(CLK), .rst(rst), .instrD(instrD), .pcPlus4D(pcPlus4D),
		.rsVal(rsVal), .rtVal(rtVal), .stallD(stallD), .flushE(flushE),
		.rsD(rsD), .rtD(rtD), .isBranchD(isBranchD),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.regWriteE(regWriteE), .aluOpE(aluOpE), .srcBSelE(srcBSelE),
		.rsValE(rsValE), .rtValE(rtValE), .rsE(rsE), .rtE(rtE), .destE(destE),
		.immSignE(immSignE), .immZeroE(immZeroE), .immUpperE(immUpperE)
	);

	executeStage i_execute (
		.CLK(CLK), .rst(rst), .regWriteE(regWriteE), .aluOpE(aluOpE),
		.srcBSelE(srcBSelE), .rsValE(rsValE), .rtValE(rtValE), .destE(destE),
		.immSignE(immSignE), .immZeroE(immZeroE), .immUpperE(immUpperE),
		.forwardA(forwardA), .forwardB(forwardB),
		.regWriteW(regWriteW), .destW(destW), .resultW(resultW)
	);

	hazardUnit i_hazard (
		.CLK(CLK), .rst(rst), .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.destE(destE), .destW(destW), .isBranchD(isBranchD),
		.branchTaken(branchTaken), .regWriteE(regWriteE), .regWriteW(regWriteW),
		.stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
		.forwardA(forwardA), .forwardB(forwardB)
	);

	// retirement is the writeback stage itself
	assign retireValid = regWriteW;
	assign retireReg = destW;
	assign retireData = resultW;

endmodule

// File: tests/mipsCoreTb.sv
`timescale 1ns/100ps
`include "mipsCfg.svh"

module mipsCoreTb;

	localparam int PROG_LEN = 200;
	localparam int RETIRE_TIMEOUT = 4000;
	localparam int DRAIN_CYCLES = 20;

	logic CLK = 1'b0;
	logic rst = 1'b1;
	mipsPkg::wordT instr;
	mipsPkg::wordT fetchPc;
	logic retireValid;
	mipsPkg::regAddrT retireReg;
	mipsPkg::wordT retireData;

	// the self loop sits at index PROG_LEN
	mipsPkg::wordT prog [PROG_LEN + 1];
	mipsPkg::regAddrT expReg [$];
	mipsPkg::wordT expData [$];

	int errors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int takenCount = 0;
	int notTakenCount = 0;

	mipsCore i_dut (
		.CLK(CLK), .rst(rst), .instr(instr), .fetchPc(fetchPc),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData)
	);

	always #50 CLK = ~CLK;

	// instruction memory answers in the same cycle, bubbles past the end
	function automatic mipsPkg::wordT fetchWord(input mipsPkg::wordT pc);
		int idx;
		idx = int'(pc >> 2);
		if (pc < mipsPkg::wordT'(4 * (PROG_LEN + 1))) begin
			return prog[idx];
		end
		return '0;
	endfunction

	always_comb begin
		instr = fetchWord(fetchPc);
	end

	function automatic mipsPkg::wordT encodeR(input mipsPkg::functE fn,
			input mipsPkg::regAddrT rd, input mipsPkg::regAddrT rs,
			input mipsPkg::regAddrT rt);
		return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsPkg::wordT encodeI(input mipsPkg::opcodeE op,
			input mipsPkg::regAddrT rt, input mipsPkg::regAddrT rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic buildProgram();
		mipsPkg::regAddrT rs;
		mipsPkg::regAddrT rt;
		mipsPkg::regAddrT rd;
		logic [15:0] imm;
		logic [15:0] offset;
		int kind;
		for (int i = 0; i < PROG_LEN; i++) begin
			// small register pool keeps dependencies close together
			rs = mipsPkg::regAddrT'($urandom_range(7));
			rt = mipsPkg::regAddrT'($urandom_range(7));
			rd = mipsPkg::regAddrT'($urandom_range(7));
			imm = 16'($urandom);
			// forward only, never past the final loop
			offset = 16'($urandom_range((PROG_LEN - 1 - i) < 3 ? (PROG_LEN - 1 - i) : 3));
			kind = $urandom_range(11);
			case (kind)
				0: prog[i] = encodeR(mipsPkg::fnAdd, rd, rs, rt);
				1: prog[i] = encodeR(mipsPkg::fnSub, rd, rs, rt);
				2: prog[i] = encodeR(mipsPkg::fnAnd, rd, rs, rt);
				3: prog[i] = encodeR(mipsPkg::fnOr, rd, rs, rt);
				4: prog[i] = encodeR(mipsPkg::fnSlt, rd, rs, rt);
				5: prog[i] = encodeI(mipsPkg::opAddi, rt, rs, imm);
				6: prog[i] = encodeI(mipsPkg::opAndi, rt, rs, imm);
				7: prog[i] = encodeI(mipsPkg::opOri, rt, rs, imm);
				8: prog[i] = encodeI(mipsPkg::opLui, rt, '0, imm);
				9: prog[i] = encodeI(mipsPkg::opBeq, rt, rs, offset);
				10: prog[i] = encodeI(mipsPkg::opBne, rt, rs, offset);
				// same register twice, always taken
				default: prog[i] = encodeI(mipsPkg::opBeq, rs, rs, offset);
			endcase
		end
		// beq $0,$0 back onto itself
		prog[PROG_LEN] = encodeI(mipsPkg::opBeq, '0, '0, 16'hffff);
	endtask

	// ISA-level run, no delay slot, queues every nonzero register write
	task automatic runModel();
		mipsPkg::wordT rf [32];
		mipsPkg::wordT w;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT res;
		mipsPkg::regAddrT dst;
		logic writes;
		int pc;
		for (int r = 0; r < 32; r++) begin
			rf[r] = '0;
		end
		pc = 0;
		while (pc < PROG_LEN) begin
			w = prog[pc];
			a = rf[w[25:21]];
			b = rf[w[20:16]];
			dst = w[20:16];
			res = '0;
			writes = 1'b1;
			pc = pc + 1;
			case (w[31:26])
				mipsPkg::opRType: begin
					dst = w[15:11];
					case (w[5:0])
						mipsPkg::fnAdd: res = a + b;
						mipsPkg::fnSub: res = a - b;
						mipsPkg::fnAnd: res = a & b;
						mipsPkg::fnOr: res = a | b;
						mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				mipsPkg::opAddi: res = a + {{16{w[15]}}, w[15:0]};
				mipsPkg::opAndi: res = a & {16'h0000, w[15:0]};
				mipsPkg::opOri: res = a | {16'h0000, w[15:0]};
				mipsPkg::opLui: res = {w[15:0], 16'h0000};
				default: begin
					// beq or bne, offset counted from the next instruction
					writes = 1'b0;
					if ((a == b) == (w[31:26] == mipsPkg::opBeq)) begin
						pc = pc + int'($signed(w[15:0]));
						takenCount++;
					end else begin
						notTakenCount++;
					end
				end
			endcase
			if (writes && (dst != '0)) begin
				rf[dst] = res;
				expReg.push_back(dst);
				expData.push_back(res);
			end
		end
	endtask

	task automatic checkReg(input mipsPkg::regAddrT got, input mipsPkg::regAddrT exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkData(input mipsPkg::wordT got, input mipsPkg::wordT exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input string detail, input int errsBefore);
		if (errors == errsBefore) begin
			testsPassed++;
			$display("%s: pass, %s", name, detail);
		end else begin
			testsFailed++;
			$display("%s: FAIL with %0d errors, %s", name, errors - errsBefore, detail);
		end
	endtask

	initial begin
		int cycles;
		int checked;
		int errsBefore;
		mipsPkg::regAddrT wantReg;
		mipsPkg::wordT wantData;

		void'($urandom(32'h0e96684f));
		buildProgram();
		runModel();
		$display("program: %0d expected writes, %0d taken and %0d not-taken branches",
			expReg.size(), takenCount, notTakenCount);

		// reset, sampled on falling edges
		errsBefore = errors;
		repeat (2) begin
			@(negedge CLK);
			checkData(fetchPc, `RESET_PC, "fetchPc during reset");
			checkFlag(retireValid, 1'b0, "retireValid during reset");
		end
		@(posedge CLK);
		rst <= 1'b0;
		// nothing reaches writeback for three cycles
		repeat (3) begin
			@(negedge CLK);
			checkFlag(retireValid, 1'b0, "retireValid before first retirement");
		end
		reportTest("reset", "pipeline idle", errsBefore);

		errsBefore = errors;
		cycles = 0;
		checked = 0;
		while ((expReg.size() > 0) && (cycles < RETIRE_TIMEOUT)) begin
			@(negedge CLK);
			cycles++;
			if (retireValid) begin
				wantReg = expReg.pop_front();
				wantData = expData.pop_front();
				checkReg(retireReg, wantReg, "retireReg");
				checkData(retireData, wantData, "retireData");
				checked++;
			end
		end

		if (expReg.size() > 0) begin
			$display("timeout: %0d expected register writes had not retired after %0d cycles",
				expReg.size(), cycles);
			$display("Test failed");
		end else begin
			reportTest("retire sequence", $sformatf("%0d writes in %0d cycles", checked, cycles),
				errsBefore);

			// the final self loop writes nothing
			errsBefore = errors;
			repeat (DRAIN_CYCLES) begin
				@(negedge CLK);
				checkFlag(retireValid, 1'b0, "retireValid after the last expected write");
			end
			reportTest("drain", "no extra retirement", errsBefore);

			$display("tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed,
				errors);
			if (errors == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/hazardUnit.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/mipsCore.sv
tests/mipsCoreTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsCoreTb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
